// File: hdl/controlSettings.svh
`ifndef CONTROL_SETTINGS_SVH
`define CONTROL_SETTINGS_SVH

// field widths
`define OPCODE_WIDTH 6
`define FUNCT_WIDTH  6
`define STATE_WIDTH  5

// opcode values
`define OP_RTYPE 6'h00   // funct field selects the operation
`define OP_J     6'h02
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_LUI   6'h0f

// funct values for the r-type opcode
`define FUNCT_NOP   6'h00
`define FUNCT_BREAK 6'h0d
`define FUNCT_ADD   6'h20
`define FUNCT_SUB   6'h22
`define FUNCT_AND   6'h24
`define FUNCT_XOR   6'h26

`endif

// File: hdl/controlPkg.sv
`default_nettype none

`include "controlSettings.svh"

package controlPkg;

	// result of decoding op and funct
	typedef enum logic [3:0]
	{
		classAdd,
		classAnd,
		classSub,
		classXor,
		classNop,
		classBreak,
		classBeq,
		classBne,
		classJump,
		classLui,
		classUndef
	} instrClassT;

	typedef enum logic [`STATE_WIDTH-1:0]
	{
		stReset,
		stFetch,
		stFetchWait1,	// memory read latency
		stFetchWait2,	// pc + 4 written here
		stDecode,
		stAdd,
		stAnd,
		stSub,
		stXor,
		stRegWrite,		// alu result to rd
		stNop,
		stBreak,		// halts until reset
		stBeq,
		stBne,
		stJump,
		stLui
	} ctrlStateT;

	// codes as the alu expects them
	typedef enum logic [2:0]
	{
		aluNone = 3'b000,
		aluAdd  = 3'b001,
		aluSub  = 3'b010,
		aluAnd  = 3'b011,
		aluXor  = 3'b110
	} aluOpT;

	typedef enum logic [1:0]
	{
		srcBReg          = 2'b00,
		srcBFour         = 2'b01,
		srcBBranchOffset = 2'b11	// sign extended, shifted by 2
	} aluSrcBT;

	typedef enum logic [1:0]
	{
		pcFromAlu    = 2'b00,
		pcFromAluOut = 2'b01,
		pcFromJump   = 2'b10
	} pcSourceT;

	typedef enum logic [1:0]
	{
		dataAluOut   = 2'b00,
		dataUpperImm = 2'b10
	} regDataSelT;

	// mux selects and alu operation for the datapath
	typedef struct packed
	{
		aluOpT      aluOp;
		logic       aluSrcA;	// 1 selects register a, 0 the pc
		aluSrcBT    aluSrcB;
		pcSourceT   pcSource;
		regDataSelT regData;
		logic       iorD;
		logic       regDst;		// 1 selects rd, 0 rt
	} datapathSelT;

	// load and write strobes
	typedef struct packed
	{
		logic irWrite;
		logic mdrLoad;
		logic aLoad;
		logic bLoad;
		logic aluOutLoad;
		logic regWrite;
		logic clear;		// clears ir, mdr, a, b, aluout and the register file
	} regCtrlT;

endpackage : controlPkg

`default_nettype wire

// File: hdl/instrDecoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "controlSettings.svh"

module instrDecoder
(
	input  wire logic [`OPCODE_WIDTH-1:0] Op,
	input  wire logic [`FUNCT_WIDTH-1:0]  Funct,
	output controlPkg::instrClassT        instrClass
);

	import controlPkg::*;

	always_comb
	begin
		instrClass = classUndef;	// anything not listed below
		case (Op)
			`OP_RTYPE:
			begin
				case (Funct)
					`FUNCT_ADD:   instrClass = classAdd;
					`FUNCT_AND:   instrClass = classAnd;
					`FUNCT_SUB:   instrClass = classSub;
					`FUNCT_XOR:   instrClass = classXor;
					`FUNCT_NOP:   instrClass = classNop;
					`FUNCT_BREAK: instrClass = classBreak;
					default:      instrClass = classUndef;
				endcase
			end

			`OP_BEQ:
			begin
				instrClass = classBeq;
			end

			`OP_BNE:
			begin
				instrClass = classBne;
			end

			`OP_J:
			begin
				instrClass = classJump;
			end

			`OP_LUI:
			begin
				instrClass = classLui;
			end

			default:
			begin
				instrClass = classUndef;	// lw and sw land here too
			end
		endcase
	end

endmodule : instrDecoder

`default_nettype wire

// File: hdl/controlSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module controlSequencer
(
	input  wire logic                   Clk,
	input  wire logic                   arstN,
	input  wire controlPkg::instrClassT instrClass,
	output controlPkg::ctrlStateT       state
);

	import controlPkg::*;

	ctrlStateT nextState;

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= stReset;
		end
		else
		begin
			state <= nextState;
		end
	end

	always_comb
	begin
		nextState = stFetch;
		case (state)
			stReset:
			begin
				nextState = stFetch;
			end

			stFetch:
			begin
				nextState = stFetchWait1;
			end

			stFetchWait1:
			begin
				nextState = stFetchWait2;
			end

			stFetchWait2:
			begin
				nextState = stDecode;
			end

			// only state that looks at the decoded instruction
			stDecode:
			begin
				case (instrClass)
					classAdd:   nextState = stAdd;
					classAnd:   nextState = stAnd;
					classSub:   nextState = stSub;
					classXor:   nextState = stXor;
					classNop:   nextState = stNop;
					classBreak: nextState = stBreak;
					classBeq:   nextState = stBeq;
					classBne:   nextState = stBne;
					classJump:  nextState = stJump;
					classLui:   nextState = stLui;
					default:    nextState = stFetch;	// undefined instructions are skipped
				endcase
			end

			stAdd, stAnd, stSub, stXor:
			begin
				nextState = stRegWrite;
			end

			stBreak:
			begin
				nextState = stBreak;	// only reset leaves
			end

			default:
			begin
				nextState = stFetch;	// regwrite and single cycle execute states
			end
		endcase
	end

endmodule : controlSequencer

`default_nettype wire

// File: hdl/controlWordGen.sv
`timescale 1ns/1ns
`default_nettype none

module controlWordGen
(
	input  wire controlPkg::ctrlStateT state,
	input  wire logic                  aluZero,
	output controlPkg::datapathSelT    datapathSel,
	output controlPkg::regCtrlT        regCtrl,
	output logic                       pcLoad
);

	import controlPkg::*;

	always_comb
	begin
		datapathSel = '0;	// everything inactive unless set below
		regCtrl = '0;
		pcLoad = 1'b0;

		case (state)
			stReset:
			begin
				regCtrl.clear = 1'b1;
			end

			// memory needs three cycles for the instruction read
			stFetch, stFetchWait1:
			begin
				regCtrl.irWrite = 1'b1;
				regCtrl.mdrLoad = 1'b1;
				datapathSel.aluSrcB = srcBFour;
			end

			stFetchWait2:
			begin
				regCtrl.irWrite = 1'b1;
				regCtrl.mdrLoad = 1'b1;
				datapathSel.aluSrcB = srcBFour;
				datapathSel.aluOp = aluAdd;		// pc + 4
				pcLoad = 1'b1;
			end

			// branch target computed ahead, in case it is needed
			stDecode:
			begin
				regCtrl.aLoad = 1'b1;
				regCtrl.bLoad = 1'b1;
				regCtrl.aluOutLoad = 1'b1;
				datapathSel.aluOp = aluAdd;
				datapathSel.aluSrcB = srcBBranchOffset;
			end

			stAdd, stAnd, stSub, stXor:
			begin
				case (state)
					stAnd:   datapathSel.aluOp = aluAnd;
					stSub:   datapathSel.aluOp = aluSub;
					stXor:   datapathSel.aluOp = aluXor;
					default: datapathSel.aluOp = aluAdd;
				endcase
				datapathSel.aluSrcA = 1'b1;		// a op b
				datapathSel.aluSrcB = srcBReg;
				regCtrl.aluOutLoad = 1'b1;
			end

			stRegWrite:
			begin
				regCtrl.regWrite = 1'b1;
				datapathSel.regDst = 1'b1;		// write rd
				datapathSel.regData = dataAluOut;
			end

			// compare by subtraction with the target already in aluout
			stBeq:
			begin
				datapathSel.aluOp = aluSub;
				datapathSel.aluSrcA = 1'b1;
				datapathSel.pcSource = pcFromAluOut;
				pcLoad = aluZero;
			end

			stBne:
			begin
				datapathSel.aluOp = aluSub;
				datapathSel.aluSrcA = 1'b1;
				datapathSel.pcSource = pcFromAluOut;
				pcLoad = !aluZero;
			end

			stJump:
			begin
				datapathSel.pcSource = pcFromJump;
				datapathSel.iorD = 1'b1;
				datapathSel.aluOp = aluAdd;
				datapathSel.aluSrcB = srcBBranchOffset;
				regCtrl.aluOutLoad = 1'b1;
				pcLoad = 1'b1;
			end

			stLui:
			begin
				regCtrl.regWrite = 1'b1;
				datapathSel.regData = dataUpperImm;
				datapathSel.regDst = 1'b0;		// write rt
			end

			default:
			begin
				datapathSel = '0;		// nop and break
				regCtrl = '0;
			end
		endcase
	end

endmodule : controlWordGen

`default_nettype wire

// File: hdl/multicycleControl.sv
`timescale 1ns/1ns
`default_nettype none

`include "controlSettings.svh"

module multicycleControl
(
	input  wire logic [`OPCODE_WIDTH-1:0] Op,
	input  wire logic [`FUNCT_WIDTH-1:0]  Funct,
	input  wire logic                     Clk,
	input  wire logic                     arstN,
	input  wire logic                     aluZero,
	output controlPkg::ctrlStateT         stateOut,
	output controlPkg::datapathSelT       datapathSel,
	output controlPkg::regCtrlT           regCtrl,
	output logic                          pcLoad
);

	import controlPkg::*;

	instrClassT instrClass;

	instrDecoder decoder
	(
		.Op         (Op),
		.Funct      (Funct),
		.instrClass (instrClass)
	);

	controlSequencer sequencer
	(
		.Clk        (Clk),
		.arstN      (arstN),
		.instrClass (instrClass),
		.state      (stateOut)
	);

	controlWordGen wordGen
	(
		.state       (stateOut),
		.aluZero     (aluZero),
		.datapathSel (datapathSel),
		.regCtrl     (regCtrl),
		.pcLoad      (pcLoad)
	);

endmodule : multicycleControl

`default_nettype wire

// File: bench/controlTbCases.svh
`ifndef CONTROL_TB_CASES_SVH
`define CONTROL_TB_CASES_SVH

localparam int NUM_CASES = 15;

// one instruction and what the unit must show in its execute cycle
typedef struct packed
{
	logic [`OPCODE_WIDTH-1:0] op;
	logic [`FUNCT_WIDTH-1:0]  funct;
	logic                     aluZero;
	ctrlStateT                execState;	// stFetch when decode drops the instruction
	logic                     regWriteNext;
	datapathSelT              expSel;
	regCtrlT                  expCtrl;
	logic                     expPcLoad;
} caseEntryT;

caseEntryT caseTable [NUM_CASES];
string     caseNames [NUM_CASES];
int        caseCount = 0;

function automatic datapathSelT makeSel(input aluOpT aluOp, input logic srcA,
	input aluSrcBT srcB, input pcSourceT pcSrc, input regDataSelT regData,
	input logic iorD, input logic regDst);
	return '{aluOp, srcA, srcB, pcSrc, regData, iorD, regDst};
endfunction

// name first, then the fields in caseEntryT order
task automatic addCase(input string name, input logic [5:0] op, input logic [5:0] funct,
	input logic zero, input ctrlStateT st, input logic rw, input datapathSelT sel,
	input regCtrlT ctrl, input logic pc);
	caseNames[caseCount] = name;
	caseTable[caseCount] = '{op, funct, zero, st, rw, sel, ctrl, pc};
	caseCount++;
endtask

task automatic loadCases();
	datapathSelT branchSel;
	datapathSelT fetchSel;
	regCtrlT     aluOutOnly;
	regCtrlT     fetchCtrl;
	regCtrlT     writeOnly;
	branchSel = makeSel(aluSub, 1'b1, srcBReg, pcFromAluOut, dataAluOut, 1'b0, 1'b0);
	fetchSel = makeSel(aluNone, 1'b0, srcBFour, pcFromAlu, dataAluOut, 1'b0, 1'b0);
	aluOutOnly = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
	fetchCtrl = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};	// ir and mdr
	writeOnly = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
	addCase("ADD", `OP_RTYPE, `FUNCT_ADD, 1'b0, stAdd, 1'b1,
		makeSel(aluAdd, 1'b1, srcBReg, pcFromAlu, dataAluOut, 1'b0, 1'b0), aluOutOnly, 1'b0);
	addCase("AND", `OP_RTYPE, `FUNCT_AND, 1'b0, stAnd, 1'b1,
		makeSel(aluAnd, 1'b1, srcBReg, pcFromAlu, dataAluOut, 1'b0, 1'b0), aluOutOnly, 1'b0);
	addCase("SUB", `OP_RTYPE, `FUNCT_SUB, 1'b1, stSub, 1'b1,
		makeSel(aluSub, 1'b1, srcBReg, pcFromAlu, dataAluOut, 1'b0, 1'b0), aluOutOnly, 1'b0);
	addCase("XOR", `OP_RTYPE, `FUNCT_XOR, 1'b0, stXor, 1'b1,
		makeSel(aluXor, 1'b1, srcBReg, pcFromAlu, dataAluOut, 1'b0, 1'b0), aluOutOnly, 1'b0);
	addCase("BEQ_Z0", `OP_BEQ, 6'h00, 1'b0, stBeq, 1'b0, branchSel, '0, 1'b0);
	addCase("BEQ_Z1", `OP_BEQ, 6'h00, 1'b1, stBeq, 1'b0, branchSel, '0, 1'b1);
	addCase("BNE_Z0", `OP_BNE, 6'h00, 1'b0, stBne, 1'b0, branchSel, '0, 1'b1);
	addCase("BNE_Z1", `OP_BNE, 6'h00, 1'b1, stBne, 1'b0, branchSel, '0, 1'b0);
	addCase("J", `OP_J, 6'h00, 1'b0, stJump, 1'b0,
		makeSel(aluAdd, 1'b0, srcBBranchOffset, pcFromJump, dataAluOut, 1'b1, 1'b0),
		aluOutOnly, 1'b1);
	addCase("LUI", `OP_LUI, 6'h00, 1'b0, stLui, 1'b0,
		makeSel(aluNone, 1'b0, srcBReg, pcFromAlu, dataUpperImm, 1'b0, 1'b0), writeOnly, 1'b0);
	addCase("NOP", `OP_RTYPE, `FUNCT_NOP, 1'b0, stNop, 1'b0, '0, '0, 1'b0);
	addCase("LW", 6'h23, 6'h00, 1'b0, stFetch, 1'b0, fetchSel, fetchCtrl, 1'b0);	// now undefined
	addCase("SW", 6'h2b, 6'h00, 1'b0, stFetch, 1'b0, fetchSel, fetchCtrl, 1'b0);
	addCase("BAD_FUNCT", `OP_RTYPE, 6'h3f, 1'b0, stFetch, 1'b0, fetchSel, fetchCtrl, 1'b0);
	addCase("BREAK", `OP_RTYPE, `FUNCT_BREAK, 1'b0, stBreak, 1'b0, '0, '0, 1'b0);	// keep last
endtask

`endif

// File: bench/multicycleControlTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "controlSettings.svh"

module multicycleControlTb;

	import controlPkg::*;

	`include "controlTbCases.svh"

	localparam int CLK_PERIOD = 100;
	localparam int WATCHDOG_CYCLES = 10 + 8 * NUM_CASES + 40;
	localparam int BREAK_HOLD = 20;

	logic                     Clk;
	logic                     arstN;
	logic [`OPCODE_WIDTH-1:0] Op;
	logic [`FUNCT_WIDTH-1:0]  Funct;
	logic                     aluZero;
	ctrlStateT                state;
	datapathSelT              datapathSel;
	regCtrlT                  regCtrl;
	logic                     pcLoad;
	int                       passCount = 0;
	int                       failCount = 0;

	multicycleControl UUT
	(
		.Op          (Op),
		.Funct       (Funct),
		.Clk         (Clk),
		.arstN       (arstN),
		.aluZero     (aluZero),
		.stateOut    (state),
		.datapathSel (datapathSel),
		.regCtrl     (regCtrl),
		.pcLoad      (pcLoad)
	);

	initial
	begin
		Clk = 1'b0;
		forever #(CLK_PERIOD / 2) Clk = ~Clk;
	end

	// hang guard
	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the control unit stopped returning to fetch");
		$display("TEST FAILED");
		$finish;
	end

	function automatic regCtrlT clearOnlyCtrl();
		return '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
	endfunction

	task automatic checkOutputs(input string testName, input ctrlStateT expState,
		input datapathSelT expSel, input regCtrlT expCtrl, input logic expPc, inout int errs);
		if (state !== expState)
		begin
			$display("FAILED %s state: expected %0d actual %0d", testName, expState, state);
			errs++;
		end
		if (datapathSel !== expSel)
		begin
			$display("FAILED %s datapathSel: expected %h actual %h", testName, expSel, datapathSel);
			errs++;
		end
		if (regCtrl !== expCtrl)
		begin
			$display("FAILED %s regCtrl: expected %b actual %b", testName, expCtrl, regCtrl);
			errs++;
		end
		if (pcLoad !== expPc)
		begin
			$display("FAILED %s pcLoad: expected %b actual %b", testName, expPc, pcLoad);
			errs++;
		end
	endtask

	task automatic applyInputs(input int idx);
		caseEntryT tc;
		if (idx < NUM_CASES)
		begin
			tc = caseTable[idx];
			Op <= tc.op;
			Funct <= tc.funct;
			aluZero <= tc.aluZero;
		end
	endtask

	// fetch cycles up to decode, starting at a falling edge in stFetch
	task automatic walkFetch(input string testName, inout int errs);
		int          steps;
		ctrlStateT   expState;
		datapathSelT expSel;
		regCtrlT     expCtrl;
		steps = 0;
		expCtrl = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
		while (state != stDecode && steps < 3)
		begin
			expSel = '0;
			expSel.aluSrcB = srcBFour;
			case (steps)
				0: expState = stFetch;
				1: expState = stFetchWait1;
				default:
				begin
					expState = stFetchWait2;
					expSel.aluOp = aluAdd;	// pc + 4
				end
			endcase
			checkOutputs(testName, expState, expSel, expCtrl, steps == 2, errs);
			@(posedge Clk);
			@(negedge Clk);
			steps++;
		end
		expSel = '0;
		expSel.aluOp = aluAdd;
		expSel.aluSrcB = srcBBranchOffset;
		expCtrl = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0};
		if (state != stDecode || steps != 3)
		begin
			$display("%s: decode state not reached after exactly three fetch cycles", testName);
			errs++;
		end
		else
			checkOutputs(testName, stDecode, expSel, expCtrl, 1'b0, errs);
	endtask

	task automatic reportTest(input string testName, input int errs);
		if (errs == 0)
		begin
			passCount++;
			$display("%s passed", testName);
		end
		else
		begin
			failCount++;
			$display("%s failed with %0d errors", testName, errs);
		end
	endtask

	task automatic runCase(input int idx);
		caseEntryT   tc;
		string       name;
		int          errs;
		datapathSelT rwSel;
		regCtrlT     rwCtrl;
		tc = caseTable[idx];
		name = caseNames[idx];
		errs = 0;
		rwSel = '0;
		rwSel.regDst = 1'b1;
		rwSel.regData = dataAluOut;
		rwCtrl = '0;
		rwCtrl.regWrite = 1'b1;
		walkFetch(name, errs);
		@(posedge Clk);
		if (tc.execState == stFetch)
			applyInputs(idx + 1);	// dropped in decode so the next fetch starts here
		@(negedge Clk);
		checkOutputs(name, tc.execState, tc.expSel, tc.expCtrl, tc.expPcLoad, errs);
		if (tc.execState == stBreak)
		begin
			repeat (BREAK_HOLD)
			begin
				@(posedge Clk);
				@(negedge Clk);
				checkOutputs(name, stBreak, '0, '0, 1'b0, errs);
			end
			@(posedge Clk);
			arstN <= 1'b0;
			@(negedge Clk);
			checkOutputs(name, stReset, '0, clearOnlyCtrl(), 1'b0, errs);
			@(posedge Clk);
			arstN <= 1'b1;
			Op <= `OP_RTYPE;
			Funct <= `FUNCT_NOP;
			@(negedge Clk);
			checkOutputs(name, stReset, '0, clearOnlyCtrl(), 1'b0, errs);
			@(posedge Clk);
			@(negedge Clk);
			walkFetch(name, errs);	// fetch resumes after reset
		end
		else if (tc.execState != stFetch)
		begin
			if (tc.regWriteNext)
			begin
				@(posedge Clk);
				@(negedge Clk);
				checkOutputs(name, stRegWrite, rwSel, rwCtrl, 1'b0, errs);
			end
			@(posedge Clk);
			applyInputs(idx + 1);
			@(negedge Clk);
			if (state !== stFetch)
			begin
				$display("FAILED %s return: expected %0d actual %0d", name, stFetch, state);
				errs++;
			end
		end
		reportTest(name, errs);
	endtask

	initial
	begin
		int errs;
		arstN <= 1'b0;
		Op <= '0;
		Funct <= '0;
		aluZero <= 1'b0;
		loadCases();
		repeat (10) @(posedge Clk);
		arstN <= 1'b1;
		@(negedge Clk);
		errs = 0;
		checkOutputs("RESET", stReset, '0, clearOnlyCtrl(), 1'b0, errs);	// one cycle left in reset
		reportTest("RESET", errs);
		@(posedge Clk);
		applyInputs(0);
		@(negedge Clk);
		for (int i = 0; i < NUM_CASES; i++)
			runCase(i);
		$display("tests passed: %0d failed: %0d", passCount, failCount);
		if (failCount == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule : multicycleControlTb

`default_nettype wire

// File: all.f
+incdir+hdl
+incdir+bench
hdl/controlPkg.sv
hdl/instrDecoder.sv
hdl/controlSequencer.sv
hdl/controlWordGen.sv
hdl/multicycleControl.sv
bench/multicycleControlTb.sv
